//--- flist.f
hw/cpu_ctrl_pkg.sv
hw/pipe_sequencer.sv
hw/stage0_decode.sv
hw/stage1_decode.sv
hw/ctrl_merge.sv
hw/cpu_control_pipe.sv
testbench/tb_clock_gen.sv
testbench/cpu_control_pipe_assert.sv
testbench/tb_cpu_control_pipe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_control_pipe
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: all run clean

//--- testbench/tb_cpu_control_pipe.sv
// testbench for the cpu control pipeline, directed tests on the datapath controls
`timescale 1ns/1ns

module tb_cpu_control_pipe import cpu_ctrl_pkg::*; ();

	localparam int TEST_CYCLES    = 140;	// reset plus summed test lengths
	localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

	logic        CLK;
	logic        RSTb;
	word_t       memory_in;
	flags_t      flags;
	dp_ctrl_t    ctrl;
	logic [15:0] lfsr;	// random source state
	int          errors;
	int          cycles;

	tb_clock_gen i_tb_clock_gen (.CLK(CLK), .RSTb(RSTb));

	cpu_control_pipe #(.PC_REG(3'd7), .LINK_REG(3'd6)) i_cpu_control_pipe (
		.CLK(CLK), .RSTb(RSTb), .memory_in(memory_in), .flags(flags), .ctrl(ctrl)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[14:0], lfsr[0]};	// one step per bit
		end
	endtask

	// active low mask, only register r selected
	function automatic logic [7:0] low_at(logic [2:0] r);
		return 8'hff ^ (8'h01 << r);
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// drive on the rising edge, controls looked at mid cycle
	task automatic step(input word_t w, input flags_t f);
		@(posedge CLK);
		memory_in <= w;
		flags     <= f;
		@(negedge CLK);
	endtask

	task automatic reset_state();
		wait (RSTb === 1'b1);
		@(negedge CLK);
		check("reset maddr_sel", 7, ctrl.maddr_sel);	// fetch through r7
		check("reset mem_oe_n", 0, ctrl.mem_oe_n);
		check("reset inc_n", 8'h7f, ctrl.inc_n);
		check("reset dec_n", 8'hff, ctrl.dec_n);
		check("reset ld_alu_n", 8'hff, ctrl.ld_alu_n);
		check("reset ld_mem_n", 8'hff, ctrl.ld_mem_n);
		check("reset mem_wr_n", 1, ctrl.mem_wr_n);
		check("reset m_en_n", 1, ctrl.m_en_n);
	endtask

	task automatic alu_reg_reg(input int n);
		logic [15:0] r;
		word_t       w;
		for (int k = 0; k < n; k++) begin
			take_bits(12, r);	// op(5) no load(1) dst(3) src(3)
			w = {4'h2, r[10:7], r[6], r[5:3], r[11], r[2:0]};
			step(w, '0);
			step(NOP_WORD, '0);	// word now in stage 0
			check("alu_rr alu_op", r[11:7], ctrl.alu_op);
			check("alu_rr alu_a_sel", r[5:3], ctrl.alu_a_sel);
			check("alu_rr alu_b_sel", r[2:0], ctrl.alu_b_sel);
			check("alu_rr ld_alu_n", r[6] ? 8'hff : low_at(r[5:3]), ctrl.ld_alu_n);
			step(NOP_WORD, '0);
		end
	endtask

	task automatic alu_reg_imm(input int n);
		logic [15:0] pre;
		logic [15:0] r;
		word_t       w;
		for (int k = 0; k < n; k++) begin
			take_bits(12, pre);
			take_bits(11, r);	// op(4) dst(3) nibble(4)
			w = {4'h3, r[10:7], 1'b0, r[6:4], r[3:0]};
			step({4'h1, pre[11:0]}, '0);	// prefix first
			step(w, '0);
			step(NOP_WORD, '0);
			check("alu_ri pout", {pre[11:0], r[3:0]}, ctrl.pout);
			check("alu_ri b_from_pout_n", 0, ctrl.alu_b_from_pout_n);
			check("alu_ri alu_op", {1'b0, r[10:7]}, ctrl.alu_op);
			check("alu_ri alu_a_sel", r[6:4], ctrl.alu_a_sel);
			step(w, '0);	// same word, prefix gone
			step(NOP_WORD, '0);
			check("alu_ri pout no prefix", {12'h000, r[3:0]}, ctrl.pout);
			step(NOP_WORD, '0);
		end
	endtask

	task automatic mem_store(input int n);
		logic [15:0] r;
		word_t       w;
		for (int k = 0; k < n; k++) begin
			take_bits(8, r);	// no dec(1) no inc(1) src(3) idx(3)
			w = {4'h5, 1'b0, r[7], r[6], 1'b1, 1'b0, r[5:3], 1'b0, r[2:0]};
			step(w, '0);
			step(NOP_WORD, '0);	// issue cycle
			check("store maddr_sel", r[2:0], ctrl.maddr_sel);
			check("store m_sel", r[5:3], ctrl.m_sel);
			check("store m_en_n", 0, ctrl.m_en_n);
			check("store mem_wr_n", 0, ctrl.mem_wr_n);
			check("store inc_n", r[6] ? 8'hff : low_at(r[2:0]), ctrl.inc_n);
			check("store dec_n", 8'h7f & (r[7] ? 8'hff : low_at(r[2:0])), ctrl.dec_n);
			step(NOP_WORD, '0);
			step(NOP_WORD, '0);
		end
	endtask

	task automatic mem_load(input int n);
		logic [15:0] r;
		word_t       w;
		for (int k = 0; k < n; k++) begin
			take_bits(8, r);	// same layout as store
			w = {4'h5, 1'b0, r[7], r[6], 1'b0, 1'b0, r[5:3], 1'b0, r[2:0]};
			step(w, '0);
			step(NOP_WORD, '0);	// issue, pc stepped back
			check("load issue dec_n", 8'h7f, ctrl.dec_n);
			check("load issue inc_n", 8'hff, ctrl.inc_n);
			step(NOP_WORD, '0);	// completion, fetch stalled
			check("load maddr_sel", r[2:0], ctrl.maddr_sel);
			check("load mem_oe_n", 0, ctrl.mem_oe_n);
			check("load ld_mem_n", low_at(r[5:3]), ctrl.ld_mem_n);
			check("load inc_n", r[6] ? 8'hff : low_at(r[2:0]), ctrl.inc_n);
			check("load dec_n", r[7] ? 8'hff : low_at(r[2:0]), ctrl.dec_n);
			step(NOP_WORD, '0);
		end
	endtask

	task automatic rel_branch(input int rounds);
		logic [15:0] r;
		word_t       w;
		word_t       ofs;
		flags_t      f;
		logic        go;
		for (int k = 0; k < rounds; k++) begin
			for (int cond = 0; cond < 8; cond++) begin
				take_bits(12, r);	// flags(3) offset(9)
				f   = flags_t'(r[11:9]);
				w   = {3'b101, 3'(cond), 1'b0, r[8:0]};
				ofs = $signed(r[8:0]);	// sign extended 9 bit offset
				case (cond)
					0: go = f.z;
					1: go = !f.z;
					2: go = f.s;
					3: go = !f.s;
					4: go = f.c;
					5: go = !f.c;
					default: go = 1'b1;	// always and link
				endcase
				step(w, '0);
				step(NOP_WORD, f);	// flags seen by stage 0
				check("branch issue inc_n", go ? 8'hff : 8'h7f, ctrl.inc_n);
				if (cond == 7) begin
					check("link ld_alu_n", 8'hbf, ctrl.ld_alu_n);	// r6 gets r7
					check("link alu_op", ALU_MOVE, ctrl.alu_op);
					check("link alu_b_sel", 7, ctrl.alu_b_sel);
				end
				step(NOP_WORD, '0);
				if (go) begin
					check("branch alu_op", ALU_ADD, ctrl.alu_op);
					check("branch alu_a_sel", 7, ctrl.alu_a_sel);
					check("branch b_from_pout_n", 0, ctrl.alu_b_from_pout_n);
					check("branch pout", ofs, ctrl.pout);
					check("branch ld_alu_n", 8'h7f, ctrl.ld_alu_n);
				end else begin
					check("branch fetch inc_n", 8'h7f, ctrl.inc_n);	// keeps fetching
				end
				step(NOP_WORD, '0);	// delay slot drains
			end
		end
	endtask

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, tests did not complete", cycles);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		memory_in = NOP_WORD;
		flags     = '0;
		lfsr      = 16'd57769;
		errors    = 0;
		cycles    = 0;
		reset_state();
		alu_reg_reg(4);
		alu_reg_imm(3);
		mem_store(4);
		mem_load(4);
		rel_branch(2);	// each condition twice
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- testbench/cpu_control_pipe_assert.sv
// bound checks on the memory bus and load controls of the cpu control pipeline
`timescale 1ns/1ns

module cpu_control_pipe_assert import cpu_ctrl_pkg::*; (
	input logic     CLK,
	input logic     RSTb,
	input dp_ctrl_t ctrl,
	input p1_tag_t  tag_next	// load issue seen from stage 0 decode
);

	a_no_rd_wr: assert property (@(posedge CLK) disable iff (!RSTb)
		!(!ctrl.mem_oe_n && !ctrl.mem_wr_n))
		else $error("memory read and write enabled together");

	a_men_wr: assert property (@(posedge CLK) disable iff (!RSTb)
		!ctrl.m_en_n |-> !ctrl.mem_wr_n)	// m_en only drives store data
		else $error("m_en_n low without a memory write");

	a_load_dst: assert property (@(posedge CLK) disable iff (!RSTb)
		tag_next.load_go |=> (ctrl.ld_mem_n != 8'hff))
		else $error("no load destination on the cycle after a load issue");

endmodule

bind cpu_control_pipe cpu_control_pipe_assert i_cpu_control_pipe_assert (
	.CLK(CLK), .RSTb(RSTb), .ctrl(ctrl), .tag_next(tag_next)
);

//--- testbench/tb_clock_gen.sv
// testbench clock and reset source, 10 ns clock with reset held low for 10 cycles
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 10
) (
	output logic CLK,
	output logic RSTb
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	initial begin
		RSTb = 1'b0;	// low from time zero
		repeat (RESET_CYCLES) @(posedge CLK);
		RSTb <= 1'b1;	// released on a rising edge, sync reset
	end

endmodule

//--- hw/cpu_control_pipe.sv
// cpu control pipeline top: sequencer, two stage decoders and control merge
`timescale 1ns/1ns

module cpu_control_pipe import cpu_ctrl_pkg::*; #(
	parameter reg_idx_t PC_REG   = 3'd7,
	parameter reg_idx_t LINK_REG = 3'd6
) (
	input  logic     CLK,
	input  logic     RSTb,
	input  word_t    memory_in,
	input  flags_t   flags,	// from ALU
	output dp_ctrl_t ctrl
);

	word_t       stage0;
	word_t       stage1;
	p1_tag_t     tag;
	p1_tag_t     tag_next;
	imm_t        imm;
	fetch_t      fetch;
	seq_req_t    req;
	stage_ctrl_t ctrl0;
	stage_ctrl_t ctrl1;

	pipe_sequencer #(.PC_REG(PC_REG)) i_pipe_sequencer (
		.CLK(CLK), .RSTb(RSTb), .memory_in(memory_in), .req(req), .tag_next(tag_next),
		.stage0(stage0), .stage1(stage1), .tag(tag), .imm(imm), .fetch(fetch)
	);

	stage0_decode #(.PC_REG(PC_REG), .LINK_REG(LINK_REG)) i_stage0_decode (
		.stage0(stage0), .flags(flags), .imm(imm), .ctrl0(ctrl0), .req(req), .tag_next(tag_next)
	);

	stage1_decode #(.PC_REG(PC_REG)) i_stage1_decode (.stage1(stage1), .tag(tag), .ctrl1(ctrl1));

	ctrl_merge #(.PC_REG(PC_REG)) i_ctrl_merge (
		.fetch(fetch), .ctrl0(ctrl0), .ctrl1(ctrl1), .imm(imm), .ctrl(ctrl)
	);

endmodule

//--- hw/ctrl_merge.sv
// control merge: fetch request plus both stage decodes into final datapath controls
`timescale 1ns/1ns

module ctrl_merge import cpu_ctrl_pkg::*; #(
	parameter reg_idx_t PC_REG = 3'd7
) (
	input  fetch_t      fetch,
	input  stage_ctrl_t ctrl0,
	input  stage_ctrl_t ctrl1,
	input  imm_t        imm,
	output dp_ctrl_t    ctrl
);

	stage_ctrl_t alu_src;	// whichever stage owns the ALU
	stage_ctrl_t mem_src;	// whichever stage owns the bus
	reg_mask_t   pc_inc_n;
	logic        pc_inc;

	always_comb begin
		if (ctrl1.alu_claim) alu_src = ctrl1;	// completion wins
		else if (ctrl0.alu_claim) alu_src = ctrl0;
		else alu_src = CTRL_IDLE;
	end

	always_comb begin
		mem_src = CTRL_IDLE;
		if (ctrl1.mem_claim) begin
			mem_src = ctrl1;
		end else if (ctrl0.mem_claim) begin
			mem_src = ctrl0;
		end else begin	// instruction fetch through pc
			mem_src.maddr_sel = PC_REG;
			mem_src.mem_oe_n  = ~fetch.active;
		end
	end

	assign pc_inc   = fetch.active && !ctrl0.hold_pc && !ctrl1.hold_pc;
	assign pc_inc_n = pc_inc ? onehot_n(PC_REG) : MASK_NONE;

	always_comb begin
		ctrl.alu_op            = alu_src.alu_op;
		ctrl.alu_a_sel         = alu_src.alu_a_sel;
		ctrl.alu_b_sel         = alu_src.alu_b_sel;
		ctrl.alu_b_from_pout_n = alu_src.b_from_pout_n;
		ctrl.pout              = {imm, alu_src.pout_lo};
		ctrl.ld_alu_n          = ctrl0.ld_alu_n & ctrl1.ld_alu_n;	// low vectors combine by AND
		ctrl.ld_mem_n          = ctrl0.ld_mem_n & ctrl1.ld_mem_n;
		ctrl.inc_n             = ctrl0.inc_n & ctrl1.inc_n & pc_inc_n;
		ctrl.dec_n             = ctrl0.dec_n & ctrl1.dec_n;
		ctrl.m_en_n            = mem_src.m_en_n;
		ctrl.m_sel             = mem_src.m_sel;
		ctrl.maddr_sel         = mem_src.maddr_sel;
		ctrl.mem_oe_n          = mem_src.mem_oe_n;
		ctrl.mem_wr_n          = mem_src.mem_wr_n;
	end

endmodule

//--- hw/stage1_decode.sv
// stage 1 decoder: completes loads and taken relative branches
`timescale 1ns/1ns

module stage1_decode import cpu_ctrl_pkg::*; #(
	parameter reg_idx_t PC_REG = 3'd7
) (
	input  word_t       stage1,
	input  p1_tag_t     tag,	// what stage 0 started
	output stage_ctrl_t ctrl1
);

	ins_class_e cls;
	reg_idx_t   idx;
	reg_idx_t   dst;

	assign cls = class_of(stage1);
	assign idx = f_idx(stage1);
	assign dst = f_dst(stage1);

	always_comb begin
		ctrl1 = CTRL_IDLE;
		if (tag.load_go && cls == MEM_RR) begin	// bus is free, fetch stalled
			ctrl1.mem_claim = 1'b1;
			ctrl1.maddr_sel = idx;
			ctrl1.mem_oe_n  = 1'b0;	// read
			ctrl1.mem_wr_n  = 1'b1;
			ctrl1.ld_mem_n  = onehot_n(dst);
			ctrl1.inc_n     = post_n(stage1[9], idx);	// post increment
			ctrl1.dec_n     = post_n(stage1[10], idx);	// post decrement
		end
		if (tag.branch_go && cls == REL_BR) begin
			// pc += {imm, low nibble}, imm loaded by stage 0
			ctrl1.alu_claim     = 1'b1;
			ctrl1.alu_op        = ALU_ADD;
			ctrl1.alu_a_sel     = PC_REG;
			ctrl1.b_from_pout_n = 1'b0;
			ctrl1.pout_lo       = f_nib(stage1);
			ctrl1.ld_alu_n      = onehot_n(PC_REG);
			ctrl1.hold_pc       = 1'b1;
		end
	end

endmodule

//--- hw/stage0_decode.sv
// stage 0 decoder: issue side controls, sequencer requests and stage 1 tag
`timescale 1ns/1ns

module stage0_decode import cpu_ctrl_pkg::*; #(
	parameter reg_idx_t PC_REG   = 3'd7,
	parameter reg_idx_t LINK_REG = 3'd6
) (
	input  word_t       stage0,
	input  flags_t      flags,
	input  imm_t        imm,
	output stage_ctrl_t ctrl0,
	output seq_req_t    req,
	output p1_tag_t     tag_next
);

	ins_class_e cls;
	logic       is_link;	// cond 111, branch and link
	logic       taken;

	// condition field bits 12:10
	function automatic logic cond_met(logic [2:0] cond, flags_t f);
		case (cond)
			3'd0: return f.z;
			3'd1: return ~f.z;
			3'd2: return f.s;
			3'd3: return ~f.s;
			3'd4: return f.c;
			3'd5: return ~f.c;
			3'd6: return 1'b1;	// always
			default: return 1'b0;	// link goes its own way
		endcase
	endfunction

	assign cls     = class_of(stage0);
	assign is_link = (stage0[12:10] == 3'b111);
	assign taken   = (cls == REL_BR) && cond_met(stage0[12:10], flags);

	always_comb begin
		ctrl0         = CTRL_IDLE;
		req           = '0;
		req.imm_value = imm;	// idle value follows held imm
		tag_next      = '0;
		case (cls)
			IMM: begin
				req.imm_load  = 1'b1;
				req.imm_value = stage0[11:0];
			end
			ALU_RR, ALU_RI: begin
				ctrl0.alu_claim = 1'b1;
				ctrl0.alu_op    = {stage0[3], stage0[11:8]};	// bit 3 is op msb
				ctrl0.alu_a_sel = f_dst(stage0);
				ctrl0.alu_b_sel = f_idx(stage0);
				if (!stage0[7])
					ctrl0.ld_alu_n = onehot_n(f_dst(stage0));	// bit 7 = flags only
				if (cls == ALU_RI) begin
					ctrl0.alu_op[4]     = 1'b0;
					ctrl0.alu_b_sel     = '0;
					ctrl0.b_from_pout_n = 1'b0;	// B from {imm, nibble}
					ctrl0.pout_lo       = f_nib(stage0);
				end
			end
			MEM_RR: begin
				ctrl0.hold_pc = 1'b1;
				req.feed_nop  = 1'b1;
				ctrl0.dec_n   = onehot_n(PC_REG);	// step pc back over dropped word
				if (stage0[8]) begin	// store, done in this cycle
					ctrl0.mem_claim = 1'b1;
					ctrl0.maddr_sel = f_idx(stage0);
					ctrl0.m_en_n    = 1'b0;
					ctrl0.m_sel     = f_dst(stage0);
					ctrl0.mem_wr_n  = 1'b0;
					ctrl0.inc_n     = post_n(stage0[9], f_idx(stage0));
					ctrl0.dec_n     = onehot_n(PC_REG) & post_n(stage0[10], f_idx(stage0));
				end else begin	// load, finished by stage 1
					req.stall        = 1'b1;
					tag_next.load_go = 1'b1;
				end
			end
			REL_BR: begin
				if (taken || is_link) begin
					ctrl0.hold_pc      = 1'b1;
					req.feed_nop       = 1'b1;
					req.delay          = 1'b1;
					tag_next.branch_go = 1'b1;
					req.imm_load       = 1'b1;
					req.imm_value      = {{7{stage0[8]}}, stage0[8:4]};	// sign extended upper
				end
				if (is_link) begin	// save return address
					ctrl0.alu_claim = 1'b1;
					ctrl0.alu_op    = ALU_MOVE;
					ctrl0.alu_b_sel = PC_REG;
					ctrl0.ld_alu_n  = onehot_n(LINK_REG);
				end
			end
			default: ;	// NOP and dropped classes
		endcase
	end

endmodule

//--- hw/pipe_sequencer.sv
// pipeline sequencer: stage registers, stall and delay slot state, held immediate, fetch request
`timescale 1ns/1ns

module pipe_sequencer import cpu_ctrl_pkg::*; #(
	parameter reg_idx_t PC_REG = 3'd7
) (
	input  logic     CLK,
	input  logic     RSTb,
	input  word_t    memory_in,	// fetched word
	input  seq_req_t req,	// from stage 0 decode
	input  p1_tag_t  tag_next,
	output word_t    stage0,
	output word_t    stage1,
	output p1_tag_t  tag,	// travels with stage1
	output imm_t     imm,
	output fetch_t   fetch
);

	logic  stall_q;	// load bubble, no fetch this cycle
	logic  delay_q;	// branch delay slot
	word_t stage0_next;
	imm_t  imm_next;

	assign stage0_next = (stall_q || delay_q || req.feed_nop) ? NOP_WORD : memory_in;

	always_comb begin
		if (req.imm_load)
			imm_next = req.imm_value;	// prefix or branch offset
		else if (req.imm_keep)
			imm_next = imm;
		else
			imm_next = '0;	// prefix covers one word only
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage0  <= NOP_WORD;
			stage1  <= NOP_WORD;
			tag     <= '0;
			stall_q <= 1'b0;
			delay_q <= 1'b0;
			imm     <= '0;
		end else begin
			stage0  <= stage0_next;
			stage1  <= stage0;	// advance unconditionally
			tag     <= tag_next;
			stall_q <= req.stall;
			delay_q <= req.delay;
			imm     <= imm_next;
		end
	end

	assign fetch.active = ~stall_q;	// delay slot still drives bus, word dropped

endmodule

//--- hw/cpu_ctrl_pkg.sv
// cpu control package: widths, instruction classes, field helpers and control structs
package cpu_ctrl_pkg;

	typedef logic [15:0] word_t;	// instruction or data word
	typedef logic [11:0] imm_t;	// upper immediate held between words
	typedef logic [3:0]  nib_t;	// low immediate field
	typedef logic [2:0]  reg_idx_t;	// register file index
	typedef logic [7:0]  reg_mask_t;	// active low, one bit per register
	typedef logic [4:0]  alu_op_t;

	localparam alu_op_t   ALU_MOVE  = 5'd0;
	localparam alu_op_t   ALU_ADD   = 5'd1;
	localparam word_t     NOP_WORD  = 16'h0000;
	localparam reg_mask_t MASK_NONE = 8'hff;	// nothing selected

	typedef enum logic [2:0] {
		NOP,
		IMM,	// 0x1 prefix
		ALU_RR,	// 0x2
		ALU_RI,	// 0x3
		MEM_RR,	// 0x5 reg index load/store
		REL_BR,	// top bits 101
		OTHER
	} ins_class_e;

	typedef struct packed {logic c; logic z; logic s;} flags_t;

	typedef struct packed {
		logic feed_nop;	// stage0 gets NOP instead of fetched word
		logic stall;	// skip next fetch
		logic delay;	// next cycle is a delay slot
		logic imm_load;
		logic imm_keep;
		imm_t imm_value;
	} seq_req_t;

	typedef struct packed {logic load_go; logic branch_go;} p1_tag_t;
	typedef struct packed {logic active;} fetch_t;

	typedef struct packed {
		logic alu_claim; alu_op_t alu_op; reg_idx_t alu_a_sel; reg_idx_t alu_b_sel;
		logic b_from_pout_n; nib_t pout_lo;
		reg_mask_t ld_alu_n; reg_mask_t ld_mem_n; reg_mask_t inc_n; reg_mask_t dec_n;
		logic mem_claim; reg_idx_t maddr_sel; logic m_en_n; reg_idx_t m_sel;
		logic mem_wr_n; logic mem_oe_n;
		logic hold_pc;	// block r7 increment
	} stage_ctrl_t;

	typedef struct packed {
		alu_op_t alu_op; reg_idx_t alu_a_sel; reg_idx_t alu_b_sel; logic alu_b_from_pout_n;
		reg_mask_t ld_alu_n; reg_mask_t ld_mem_n; reg_mask_t inc_n; reg_mask_t dec_n;
		logic m_en_n; reg_idx_t m_sel; reg_idx_t maddr_sel; logic mem_oe_n; logic mem_wr_n;
		word_t pout;
	} dp_ctrl_t;

	localparam stage_ctrl_t CTRL_IDLE = '{
		alu_op: ALU_MOVE, b_from_pout_n: 1'b1, ld_alu_n: MASK_NONE, ld_mem_n: MASK_NONE,
		inc_n: MASK_NONE, dec_n: MASK_NONE, m_en_n: 1'b1, mem_wr_n: 1'b1, mem_oe_n: 1'b1,
		default: '0
	};

	function automatic ins_class_e class_of(word_t w);
		if (w == NOP_WORD) return NOP;
		if (w[15:13] == 3'b101) return REL_BR;
		case (w[15:12])
			4'h1: return IMM;
			4'h2: return ALU_RR;
			4'h3: return ALU_RI;
			4'h5: return MEM_RR;
			default: return OTHER;	// dropped classes decode as nothing
		endcase
	endfunction

	function automatic reg_idx_t f_dst(word_t w); return w[6:4]; endfunction	// dest / store src
	function automatic reg_idx_t f_idx(word_t w); return w[2:0]; endfunction	// src / mem index
	function automatic nib_t f_nib(word_t w); return w[3:0]; endfunction

	function automatic reg_mask_t onehot_n(reg_idx_t i);
		return ~(reg_mask_t'(1) << i);
	endfunction

	// post update mask, bit low means apply
	function automatic reg_mask_t post_n(logic act_n, reg_idx_t i);
		return act_n ? MASK_NONE : onehot_n(i);
	endfunction

endpackage
